//--- list.f
+incdir+.
rv32i_types.sv
mem_types.sv
arbiter.sv
line_memory.sv
mem_subsys.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_mem_subsys -Mdir obj_dir -o tb_mem_subsys -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_mem_subsys)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- mem_golden.txt
// header addr; header is id, client (1 inst, 2 data), op (0 read, 1 write), overlap, 0, delay
// next line is the line, word 0 first: wdata for a write, expected rdata for a read
01210000 00000040
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
02200000 00000040
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
03100000 00000040
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
04100000 0000005c
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
05210000 00000080
deadbeef cafef00d 01234567 89abcdef 76543210 fedcba98 5a5aa5a5 0f0ff0f0
06210000 000007e0
33330000 33330011 33330022 33330033 33330044 33330055 33330066 33330077
07200000 00000080
deadbeef cafef00d 01234567 89abcdef 76543210 fedcba98 5a5aa5a5 0f0ff0f0
08101000 000007e0
33330000 33330011 33330022 33330033 33330044 33330055 33330066 33330077
09210000 00000100
44440000 44441111 44442222 44443333 44444444 44445555 44446666 44447777
0a101002 00000080
deadbeef cafef00d 01234567 89abcdef 76543210 fedcba98 5a5aa5a5 0f0ff0f0
0b200000 00000100
44440000 44441111 44442222 44443333 44444444 44445555 44446666 44447777
0c200000 000007e0
33330000 33330011 33330022 33330033 33330044 33330055 33330066 33330077
0d100000 00000840
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007

//--- tb_mem_subsys.sv
`include "mem_defs.svh"

module tb_mem_subsys
    import rv32i_types::*;
    import mem_types::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RECORDS  = 13;
    localparam int REC_WORDS    = 10;  // header, addr, eight line words.
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + IDLE_CYCLES + NUM_RECORDS * (`MEM_LATENCY + 4) * 2;

    localparam logic [3:0] CLIENT_INST = 4'd1;
    localparam logic [3:0] OP_WRITE    = 4'd1;

    logic      clk = 1'b0;
    logic      rst;
    logic      inst_read;
    rv32i_word inst_addr;
    mem_rsp_t  inst_rsp;
    mem_req_t  data_req;
    mem_rsp_t  data_rsp;

    logic [31:0] golden [NUM_RECORDS * REC_WORDS];
    logic [7:0]  rec_id      [NUM_RECORDS];
    logic [3:0]  rec_client  [NUM_RECORDS];
    logic [3:0]  rec_op      [NUM_RECORDS];
    logic [3:0]  rec_overlap [NUM_RECORDS];
    logic [7:0]  rec_delay   [NUM_RECORDS];
    rv32i_word   rec_addr    [NUM_RECORDS];
    mem_line_t   rec_line    [NUM_RECORDS];

    int        launch_cycle [NUM_RECORDS];
    int        resp_cycle   [NUM_RECORDS];
    mem_line_t got_line     [NUM_RECORDS];
    bit        single_pulse [NUM_RECORDS];

    int cycle  = 0;
    int passed = 0;
    int errors = 0;

    mem_subsys uut (
        .clk       (clk),
        .rst       (rst),
        .inst_read (inst_read),
        .inst_addr (inst_addr),
        .inst_rsp  (inst_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    // true when every header carries its own record number.
    function automatic bit load_records();
        bit ok;
        int base;
        ok = 1'b1;
        $readmemh("mem_golden.txt", golden);
        for (int i = 0; i < NUM_RECORDS; i++) begin
            base           = i * REC_WORDS;
            rec_id[i]      = golden[base][31:24];
            rec_client[i]  = golden[base][23:20];
            rec_op[i]      = golden[base][19:16];
            rec_overlap[i] = golden[base][15:12];
            rec_delay[i]   = golden[base][7:0];
            rec_addr[i]    = golden[base + 1];
            for (int k = 0; k < 8; k++) begin
                rec_line[i][32 * k +: 32] = golden[base + 2 + k];
            end
            if (rec_id[i] !== 8'(i + 1)) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic string test_name(input int i);
        string who;
        string what;
        who  = (rec_client[i] == CLIENT_INST) ? "inst" : "data";
        what = (rec_op[i] == OP_WRITE) ? "write" : "read";
        return $sformatf("test %0d %s %s %h", rec_id[i], who, what, rec_addr[i]);
    endfunction

    function automatic mem_rsp_t client_rsp(input int i);
        if (rec_client[i] == CLIENT_INST) return inst_rsp;
        return data_rsp;
    endfunction

    task automatic set_request(input int i, input logic on);
        if (rec_client[i] == CLIENT_INST) begin
            inst_read <= on;
            inst_addr <= on ? rec_addr[i] : '0;
        end else begin
            data_req.read  <= on && (rec_op[i] != OP_WRITE);
            data_req.write <= on && (rec_op[i] == OP_WRITE);
            data_req.addr  <= on ? rec_addr[i] : '0;
            data_req.wdata <= (on && rec_op[i] == OP_WRITE) ? rec_line[i] : '0;
        end
    endtask

    // raise the request, hold it until resp, drop it at the next edge.
    task automatic run_access(input int i);
        mem_rsp_t rsp;
        @(posedge clk);
        launch_cycle[i] = cycle + 1;
        set_request(i, 1'b1);
        rsp = '0;
        while (!rsp.resp) begin
            @(negedge clk);
            rsp = client_rsp(i);
        end
        resp_cycle[i] = cycle;
        got_line[i]   = rsp.rdata;
        @(posedge clk);
        set_request(i, 1'b0);
        @(negedge clk);
        rsp = client_rsp(i);
        single_pulse[i] = !rsp.resp;
    endtask

    task automatic check_result(input int i, input bit with_latency, input int partner);
        int    latency;
        int    inst_idx;
        int    data_idx;
        string line;
        latency  = resp_cycle[i] - launch_cycle[i];
        inst_idx = (rec_client[i] == CLIENT_INST) ? i : partner;
        data_idx = (rec_client[i] == CLIENT_INST) ? partner : i;
        line     = "";
        if (rec_op[i] != OP_WRITE && got_line[i] !== rec_line[i]) begin
            line = $sformatf("error %s: expected %h actual %h",
                             test_name(i), rec_line[i], got_line[i]);
        end else if (with_latency && latency != `MEM_LATENCY + 2) begin
            line = $sformatf("error %s latency: expected %0d actual %0d",
                             test_name(i), `MEM_LATENCY + 2, latency);
        end else if (!single_pulse[i]) begin
            line = $sformatf("%s: resp stayed high for more than one cycle", test_name(i));
        end else if (partner >= 0 && resp_cycle[inst_idx] <= resp_cycle[data_idx]) begin
            line = $sformatf("%s: inst resp at cycle %0d did not follow data resp at cycle %0d",
                             test_name(i), resp_cycle[inst_idx], resp_cycle[data_idx]);
        end
        if (line == "") begin
            passed++;
            $display("%s: ok", test_name(i));
        end else begin
            errors++;
            $display("%s", line);
        end
    endtask

    task automatic check_idle();
        logic seen;
        seen = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (inst_rsp.resp || data_rsp.resp) seen = 1'b1;
        end
        if (seen) begin
            errors++;
            $display("error test 0 idle after reset: expected resp 0 actual 1");
        end else begin
            passed++;
            $display("test 0 idle after reset: ok");
        end
    endtask

    // the second record starts rec_delay edges after the first one.
    task automatic run_pair(input int i);
        fork
            run_access(i);
            begin
                repeat (rec_delay[i + 1]) @(posedge clk);
                run_access(i + 1);
            end
        join
        check_result(i, 1'b0, -1);
        check_result(i + 1, 1'b0, i);
    endtask

    task automatic run_all_tests();
        int i;
        check_idle();
        i = 0;
        while (i < NUM_RECORDS) begin
            if (i + 1 < NUM_RECORDS && rec_overlap[i + 1] != 4'd0) begin
                run_pair(i);
                i += 2;
            end else begin
                run_access(i);
                check_result(i, 1'b1, -1);
                i += 1;
            end
        end
    endtask

    initial begin
        rst       <= 1'b1;
        inst_read <= 1'b0;
        inst_addr <= '0;
        data_req  <= '0;
        if (load_records()) begin
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b0;
            run_all_tests();
            $display("%0d tests passed, %0d tests failed", passed, errors);
            if (errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
        end else begin
            $display("mem_golden.txt could not be read or its records are out of order");
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_mem_subsys

//--- mem_subsys.sv
module mem_subsys
    import rv32i_types::*;
    import mem_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction cache side.
    input  logic      inst_read,
    input  rv32i_word inst_addr,
    output mem_rsp_t  inst_rsp,

    // data cache side.
    input  mem_req_t  data_req,
    output mem_rsp_t  data_rsp
);

    // shared line port between arbiter and memory.
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .inst_read (inst_read),
        .inst_addr (inst_addr),
        .inst_rsp  (inst_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    line_memory u_line_memory (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule : mem_subsys

//--- line_memory.sv
`include "mem_defs.svh"

module line_memory
    import rv32i_types::*;
    import mem_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int OFFSET_BITS = $clog2(`MEM_LINE_BITS / 8);
    localparam int CNT_BITS    = $clog2(`MEM_LATENCY + 1);

    mem_line_t lines [`MEM_LINES];

    mem_state_e state;
    logic [CNT_BITS-1:0] cnt;

    // captured at the start of an access.
    logic                       write_q;
    logic [`MEM_INDEX_BITS-1:0] index_q;
    mem_line_t                  wdata_q;
    mem_line_t                  rdata_q;

    logic start;
    logic finish;

    function automatic logic [`MEM_INDEX_BITS-1:0] line_index(input rv32i_word addr);
        // offset bits and bits above the index are ignored.
        return addr[OFFSET_BITS +: `MEM_INDEX_BITS];
    endfunction

    assign start  = (state == mem_idle) && (mem_req.read || mem_req.write);
    assign finish = (state == mem_busy) && (cnt == CNT_BITS'(`MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_idle;
            cnt   <= '0;
        end else begin
            case (state)
                mem_idle: begin
                    cnt <= '0;
                    if (start) begin
                        state <= mem_busy;
                    end
                end

                mem_busy: begin
                    if (finish) begin
                        state <= mem_done;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                mem_done: state <= mem_idle;  // resp lasts one cycle.

                default: state <= mem_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            write_q <= mem_req.write;
            index_q <= line_index(mem_req.addr);
            wdata_q <= mem_req.wdata;
        end
        if (finish) begin
            if (write_q) begin
                lines[index_q] <= wdata_q;
                rdata_q        <= wdata_q;
            end else begin
                rdata_q <= lines[index_q];
            end
        end
    end

    assign mem_rsp.resp  = (state == mem_done);
    assign mem_rsp.rdata = (state == mem_done) ? rdata_q : '0;

endmodule : line_memory

//--- arbiter.sv
module arbiter
    import rv32i_types::*;
    import mem_types::*;
(
    input  logic       clk,
    input  logic       rst,

    // instruction client, read only.
    input  logic       inst_read,
    input  rv32i_word  inst_addr,
    output mem_rsp_t   inst_rsp,

    // data client.
    input  mem_req_t   data_req,
    output mem_rsp_t   data_rsp,

    // shared line port.
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    arb_state_e state;
    arb_state_e next_state;

    logic inst_wants;
    logic data_wants;
    logic done;

    assign inst_wants = inst_read;
    assign data_wants = data_req.read | data_req.write;
    assign done       = mem_rsp.resp;

    // data side wins from idle; on a resp the port goes to the other side if it waits.
    always_comb begin
        next_state = state;
        case (state)
            arb_idle: begin
                if (data_wants) begin
                    next_state = arb_dcache;
                end else if (inst_wants) begin
                    next_state = arb_icache;
                end
            end

            arb_icache: begin
                if (done) begin
                    next_state = data_wants ? arb_dcache : arb_idle;
                end
            end

            arb_dcache: begin
                if (done) begin
                    next_state = inst_wants ? arb_icache : arb_idle;
                end
            end

            default: begin
                next_state = arb_idle;
            end
        endcase
    end

    // steer request and response by grant.
    always_comb begin
        mem_req  = '0;  // idle keeps the port quiet.
        inst_rsp = '0;
        data_rsp = '0;
        case (state)
            arb_icache: begin
                mem_req.read  = inst_read;
                mem_req.write = 1'b0;
                mem_req.addr  = inst_addr;
                mem_req.wdata = '0;
                inst_rsp      = mem_rsp;
            end

            arb_dcache: begin
                mem_req  = data_req;
                data_rsp = mem_rsp;
            end

            default: begin
                mem_req  = '0;
                inst_rsp = '0;
                data_rsp = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule : arbiter

//--- mem_types.sv
`include "mem_defs.svh"

package mem_types;

    import rv32i_types::*;

    typedef logic [`MEM_LINE_BITS-1:0] mem_line_t;

    // request toward memory, 290 bits.
    typedef struct packed {
        logic      read;
        logic      write;
        rv32i_word addr;
        mem_line_t wdata;
    } mem_req_t;

    // response from memory, 257 bits.
    typedef struct packed {
        logic      resp;  // one-cycle pulse per access.
        mem_line_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_icache,
        arb_dcache
    } arb_state_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_busy,
        mem_done
    } mem_state_e;

endpackage : mem_types

//--- rv32i_types.sv
package rv32i_types;

    // byte address or data word of the core.
    typedef logic [31:0] rv32i_word;

endpackage : rv32i_types

//--- mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// width of one line on the memory port, eight 32-bit words.
`define MEM_LINE_BITS 256

// depth of the main memory model in lines.
`define MEM_LINES 64

// line index is taken from address bits 10:5.
`define MEM_INDEX_BITS 6

// busy cycles between the start of an access and its resp.
`define MEM_LATENCY 4

`endif
